/* src/VideoTxPkg.sv */
// Video transmitter shared widths, lane count, latency and the pattern opcode enum
package VideoTxPkg;

	// --------------------
	// Display geometry
	// --------------------

	// Horizontal size and position width
	localparam int HdisplayWidth = 11;
	// Vertical size and position width
	localparam int VdisplayWidth = 11;

	// --------------------
	// Colour lanes
	// --------------------

	// One colour component, also one lane level
	localparam int ColorBits = 4;
	// Red, green, blue in that order
	localparam int LaneCount = 3;
	// Position outputs to registered lane output
	localparam int LaneLatency = 1;

	// --------------------
	// Backlight
	// --------------------

	// Duty and period counter width
	localparam int PwmBits = 8;

	// --------------------
	// Pattern opcode
	// --------------------

	// Solid   component is the level
	// HRamp   low bits of x plus level
	// VRamp   low bits of y plus level
	// Checker level where x[3] and y[3] differ
	typedef enum logic [1:0]
	{
		patSolid   = 2'd0,
		patHRamp   = 2'd1,
		patVRamp   = 2'd2,
		patChecker = 2'd3
	} patternMode_t;

endpackage

/* src/VideoSyncGen.sv */
// Programmable horizontal and vertical timing generator with sync, enable, position and frame end
`timescale 1ns/10ps

module VideoSyncGen
(
	input  logic                                iVideoClk,
	input  logic                                reset,
	// Active region size
	input  logic [VideoTxPkg::HdisplayWidth-1:0] hDisplay,
	input  logic [VideoTxPkg::VdisplayWidth-1:0] vDisplay,
	// Sync windows and wrap points
	input  logic [VideoTxPkg::HdisplayWidth:0]   hSyncStart,
	input  logic [VideoTxPkg::HdisplayWidth:0]   hSyncEnd,
	input  logic [VideoTxPkg::HdisplayWidth:0]   hSyncMax,
	input  logic [VideoTxPkg::VdisplayWidth:0]   vSyncStart,
	input  logic [VideoTxPkg::VdisplayWidth:0]   vSyncEnd,
	input  logic [VideoTxPkg::VdisplayWidth:0]   vSyncMax,
	// Registered timing outputs
	output logic                                hSyncRaw,
	output logic                                vSyncRaw,
	output logic                                deRaw,
	output logic [VideoTxPkg::HdisplayWidth-1:0] pixelX,
	output logic [VideoTxPkg::VdisplayWidth-1:0] pixelY,
	output logic                                frameEnd
);

	import VideoTxPkg::*;

	// --------------------
	// Counters
	// --------------------

	// One bit wider than the display size
	logic [HdisplayWidth:0] hCount;
	logic [VdisplayWidth:0] vCount;

	// Last pixel of a line / last line of a frame
	logic hWrap;
	logic vWrap;

	assign hWrap = (hCount == hSyncMax);
	assign vWrap = (vCount == vSyncMax);

	// Horizontal counter advances vertical on wrap
	always_ff @(posedge iVideoClk)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (hWrap)
		begin
			hCount <= '0;
			if (vWrap)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	// --------------------
	// Window compares
	// --------------------

	logic hActive;
	logic vActive;
	logic deNext;
	logic hSyncNext;
	logic vSyncNext;

	// Display size zero-extended to counter width
	assign hActive = (hCount < {1'b0, hDisplay});
	assign vActive = (vCount < {1'b0, vDisplay});
	assign deNext  = hActive && vActive;

	// Active high, start inclusive, end exclusive
	assign hSyncNext = (hCount >= hSyncStart) && (hCount < hSyncEnd);
	assign vSyncNext = (vCount >= vSyncStart) && (vCount < vSyncEnd);

	// --------------------
	// Output register
	// --------------------

	// Everything one clock after the counter state
	always_ff @(posedge iVideoClk)
	begin
		if (reset)
		begin
			hSyncRaw <= 1'b0;
			vSyncRaw <= 1'b0;
			deRaw    <= 1'b0;
			pixelX   <= '0;
			pixelY   <= '0;
			frameEnd <= 1'b0;
		end
		else
		begin
			hSyncRaw <= hSyncNext;
			vSyncRaw <= vSyncNext;
			deRaw    <= deNext;
			// Position only inside the active region
			pixelX   <= deNext ? hCount[HdisplayWidth-1:0] : '0;
			pixelY   <= deNext ? vCount[VdisplayWidth-1:0] : '0;
			// Single pulse on the very last clock
			frameEnd <= hWrap && vWrap;
		end
	end

endmodule

/* src/ColorLane.sv */
// Single colour lane computing one registered component from position, opcode and level
`timescale 1ns/10ps

module ColorLane
(
	input  logic                                 iVideoClk,
	input  logic                                 reset,
	input  VideoTxPkg::patternMode_t             patternMode,
	input  logic [VideoTxPkg::HdisplayWidth-1:0] pixelX,
	input  logic [VideoTxPkg::VdisplayWidth-1:0] pixelY,
	// Per-lane base level
	input  logic [VideoTxPkg::ColorBits-1:0]     level,
	output logic [VideoTxPkg::ColorBits-1:0]     color
);

	import VideoTxPkg::*;

	// --------------------
	// Pattern decode
	// --------------------

	logic [ColorBits-1:0] colorNext;
	// Checker cell select
	logic                 cellOdd;

	// Bit 3 of x against bit 3 of y
	assign cellOdd = pixelX[ColorBits-1] ^ pixelY[ColorBits-1];

	always_comb
	begin
		case (patternMode)
			patSolid:
				colorNext = level;
			// Ramps wrap within the component width
			patHRamp:
				colorNext = pixelX[ColorBits-1:0] + level;
			patVRamp:
				colorNext = pixelY[ColorBits-1:0] + level;
			patChecker:
				colorNext = cellOdd ? level : '0;
			default:
				colorNext = '0;
		endcase
	end

	// --------------------
	// Lane register
	// --------------------

	// One clock of lane latency
	always_ff @(posedge iVideoClk)
	begin
		if (reset)
			color <= '0;
		else
			color <= colorNext;
	end

endmodule

/* src/TftOutput.sv */
// Panel output stage aligning sync and enable with lane latency and registering all pins
`timescale 1ns/10ps

module TftOutput
(
	input  logic                                                    iVideoClk,
	input  logic                                                    reset,
	// Raw timing from the sync generator
	input  logic                                                    hSyncRaw,
	input  logic                                                    vSyncRaw,
	input  logic                                                    deRaw,
	// Red in the top slice, blue in the bottom
	input  logic [VideoTxPkg::LaneCount*VideoTxPkg::ColorBits-1:0] laneColor,
	// Panel pins
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorR,
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorG,
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorB,
	output logic                                                    tftHSync,
	output logic                                                    tftVSync,
	output logic                                                    tftDe
);

	import VideoTxPkg::*;

	// --------------------
	// Sync delay line
	// --------------------

	// Index 0 is the newest stage
	logic [LaneLatency-1:0] hSyncDly;
	logic [LaneLatency-1:0] vSyncDly;
	logic [LaneLatency-1:0] deDly;

	always_ff @(posedge iVideoClk)
	begin
		if (reset)
		begin
			hSyncDly <= '0;
			vSyncDly <= '0;
			deDly    <= '0;
		end
		else
		begin
			hSyncDly[0] <= hSyncRaw;
			vSyncDly[0] <= vSyncRaw;
			deDly[0]    <= deRaw;
			// Deeper stages only when latency grows
			for (int i = 1; i < LaneLatency; i++)
			begin
				hSyncDly[i] <= hSyncDly[i-1];
				vSyncDly[i] <= vSyncDly[i-1];
				deDly[i]    <= deDly[i-1];
			end
		end
	end

	// --------------------
	// Pin register
	// --------------------

	// Enable aligned with lane output
	logic deAligned;

	assign deAligned = deDly[LaneLatency-1];

	// Colour and enable leave together
	always_ff @(posedge iVideoClk)
	begin
		if (reset)
		begin
			tftHSync  <= 1'b0;
			tftVSync  <= 1'b0;
			tftDe     <= 1'b0;
			tftColorR <= '0;
			tftColorG <= '0;
			tftColorB <= '0;
		end
		else
		begin
			tftHSync  <= hSyncDly[LaneLatency-1];
			tftVSync  <= vSyncDly[LaneLatency-1];
			tftDe     <= deAligned;
			// Blanking outside the active region
			tftColorR <= deAligned ? laneColor[2*ColorBits +: ColorBits] : '0;
			tftColorG <= deAligned ? laneColor[ColorBits +: ColorBits] : '0;
			tftColorB <= deAligned ? laneColor[0 +: ColorBits] : '0;
		end
	end

endmodule

/* src/BacklightPwm.sv */
// Free-running backlight PWM with duty captured at each period start
`timescale 1ns/10ps

module BacklightPwm
(
	input  logic                           iVideoClk,
	input  logic                           reset,
	input  logic [VideoTxPkg::PwmBits-1:0] blDuty,
	output logic                           tftBackLight
);

	import VideoTxPkg::*;

	// Period counter, wraps every 2**PwmBits clocks
	logic [PwmBits-1:0] pwmCount;
	// Duty held for the rest of the period
	logic [PwmBits-1:0] dutyCap;
	logic               periodStart;
	logic [PwmBits-1:0] dutyNow;

	assign periodStart = (pwmCount == '0);
	// New duty takes effect on the first count
	assign dutyNow     = periodStart ? blDuty : dutyCap;

	always_ff @(posedge iVideoClk)
	begin
		if (periodStart)
			dutyCap <= blDuty;
	end

	always_ff @(posedge iVideoClk)
	begin
		if (reset)
		begin
			pwmCount     <= '0;
			tftBackLight <= 1'b0;
		end
		else
		begin
			pwmCount     <= pwmCount + 1'b1;
			// High for exactly dutyNow counts
			tftBackLight <= (pwmCount < dutyNow);
		end
	end

endmodule

/* src/VideoTxUnit.sv */
// Video transmitter top with sync generator, colour lane loop, panel output stage and backlight PWM
`timescale 1ns/10ps

module VideoTxUnit
(
	input  logic                                                    iVideoClk,
	input  logic                                                    reset,
	// Timing programme
	input  logic [VideoTxPkg::HdisplayWidth-1:0]                    hDisplay,
	input  logic [VideoTxPkg::VdisplayWidth-1:0]                    vDisplay,
	input  logic [VideoTxPkg::HdisplayWidth:0]                      hSyncStart,
	input  logic [VideoTxPkg::HdisplayWidth:0]                      hSyncEnd,
	input  logic [VideoTxPkg::HdisplayWidth:0]                      hSyncMax,
	input  logic [VideoTxPkg::VdisplayWidth:0]                      vSyncStart,
	input  logic [VideoTxPkg::VdisplayWidth:0]                      vSyncEnd,
	input  logic [VideoTxPkg::VdisplayWidth:0]                      vSyncMax,
	// Pattern control
	input  VideoTxPkg::patternMode_t                                patternMode,
	input  logic [VideoTxPkg::LaneCount*VideoTxPkg::ColorBits-1:0] laneLevel,
	input  logic [VideoTxPkg::PwmBits-1:0]                          blDuty,
	// Panel pins
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorR,
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorG,
	output logic [VideoTxPkg::ColorBits-1:0]                        tftColorB,
	output logic                                                    tftHSync,
	output logic                                                    tftVSync,
	output logic                                                    tftDe,
	output logic                                                    tftBackLight,
	// Last clock of each frame
	output logic                                                    frameEnd
);

	import VideoTxPkg::*;

	// --------------------
	// Sync generator
	// --------------------

	logic                     hSyncRaw;
	logic                     vSyncRaw;
	logic                     deRaw;
	logic [HdisplayWidth-1:0] pixelX;
	logic [VdisplayWidth-1:0] pixelY;

	VideoSyncGen syncGen_i
	(
		.iVideoClk  (iVideoClk),
		.reset      (reset),
		.hDisplay   (hDisplay),
		.vDisplay   (vDisplay),
		.hSyncStart (hSyncStart),
		.hSyncEnd   (hSyncEnd),
		.hSyncMax   (hSyncMax),
		.vSyncStart (vSyncStart),
		.vSyncEnd   (vSyncEnd),
		.vSyncMax   (vSyncMax),
		.hSyncRaw   (hSyncRaw),
		.vSyncRaw   (vSyncRaw),
		.deRaw      (deRaw),
		.pixelX     (pixelX),
		.pixelY     (pixelY),
		.frameEnd   (frameEnd)
	);

	// --------------------
	// Colour lanes
	// --------------------

	// Lane 0 is red in the top slice
	logic [LaneCount*ColorBits-1:0] laneColor;

	for (genvar lane = 0; lane < LaneCount; lane++)
	begin : genLane
		ColorLane lane_i
		(
			.iVideoClk   (iVideoClk),
			.reset       (reset),
			.patternMode (patternMode),
			.pixelX      (pixelX),
			.pixelY      (pixelY),
			.level       (laneLevel[(LaneCount-1-lane)*ColorBits +: ColorBits]),
			.color       (laneColor[(LaneCount-1-lane)*ColorBits +: ColorBits])
		);
	end

	// --------------------
	// Output stage
	// --------------------

	TftOutput tftOut_i
	(
		.iVideoClk (iVideoClk),
		.reset     (reset),
		.hSyncRaw  (hSyncRaw),
		.vSyncRaw  (vSyncRaw),
		.deRaw     (deRaw),
		.laneColor (laneColor),
		.tftColorR (tftColorR),
		.tftColorG (tftColorG),
		.tftColorB (tftColorB),
		.tftHSync  (tftHSync),
		.tftVSync  (tftVSync),
		.tftDe     (tftDe)
	);

	// Backlight dimming
	BacklightPwm blPwm_i
	(
		.iVideoClk    (iVideoClk),
		.reset        (reset),
		.blDuty       (blDuty),
		.tftBackLight (tftBackLight)
	);

endmodule

/* tests/VideoTx_sva.sv */
// Concurrent assertions on the video transmitter pins, bound to the top level
`timescale 1ns/10ps

module VideoTxSva
(
	input logic                                 iVideoClk,
	input logic                                 reset,
	input logic [VideoTxPkg::ColorBits-1:0]     tftColorR,
	input logic [VideoTxPkg::ColorBits-1:0]     tftColorG,
	input logic [VideoTxPkg::ColorBits-1:0]     tftColorB,
	input logic                                 tftHSync,
	input logic                                 tftVSync,
	input logic                                 tftDe,
	input logic                                 tftBackLight,
	input logic                                 frameEnd
);

	// Assertion failure count
	int assertFails = 0;

	// --------------------
	// Reset state
	// --------------------

	// All timing pins and the backlight low one clock after reset
	resetClearsPins: assert property (@(posedge iVideoClk)
		reset |=> (!tftHSync && !tftVSync && !tftDe && !tftBackLight && !frameEnd))
		else
		begin
			$error("Pins not cleared in the cycle after reset");
			assertFails++;
		end

	// --------------------
	// Blanking and pulses
	// --------------------

	// No colour outside the active region
	blankColour: assert property (@(posedge iVideoClk)
		!tftDe |-> (tftColorR == '0 && tftColorG == '0 && tftColorB == '0))
		else
		begin
			$error("Colour pins not zero while tftDe is low");
			assertFails++;
		end

	// Frame end lasts one clock
	frameEndPulse: assert property (@(posedge iVideoClk) disable iff (reset)
		frameEnd |=> !frameEnd)
		else
		begin
			$error("frameEnd held longer than one clock");
			assertFails++;
		end

endmodule

bind VideoTxUnit VideoTxSva sva_i
(
	.iVideoClk    (iVideoClk),
	.reset        (reset),
	.tftColorR    (tftColorR),
	.tftColorG    (tftColorG),
	.tftColorB    (tftColorB),
	.tftHSync     (tftHSync),
	.tftVSync     (tftVSync),
	.tftDe        (tftDe),
	.tftBackLight (tftBackLight),
	.frameEnd     (frameEnd)
);

/* tests/VideoTxChecker.sv */
// Pin watcher with expected pixels, frame geometry, backlight duty and error counts
`timescale 1ns/10ps

module VideoTxChecker
(
	input  logic                                                    iVideoClk,
	input  logic                                                    reset,
	// Strobe at the end of each table entry
	input  logic                                                    testEnd,
	input  logic [8*12-1:0]                                         testName,
	input  logic [VideoTxPkg::HdisplayWidth-1:0]                    hDisplay,
	input  logic [VideoTxPkg::VdisplayWidth-1:0]                    vDisplay,
	input  logic [VideoTxPkg::HdisplayWidth:0]                      hSyncStart,
	input  logic [VideoTxPkg::HdisplayWidth:0]                      hSyncEnd,
	input  VideoTxPkg::patternMode_t                                patternMode,
	input  logic [VideoTxPkg::LaneCount*VideoTxPkg::ColorBits-1:0] laneLevel,
	input  logic [VideoTxPkg::PwmBits-1:0]                          blDuty,
	input  logic [VideoTxPkg::ColorBits-1:0]                        tftColorR,
	input  logic [VideoTxPkg::ColorBits-1:0]                        tftColorG,
	input  logic [VideoTxPkg::ColorBits-1:0]                        tftColorB,
	input  logic                                                    tftHSync,
	input  logic                                                    tftVSync,
	input  logic                                                    tftDe,
	input  logic                                                    tftBackLight,
	output int                                                      errorCount,
	output int                                                      testsRun,
	output int                                                      testsFailed
);

	import VideoTxPkg::*;

	// Position, counted from the pins
	int xPos;
	int lineIdx;
	int framesSeen;
	// Backlight window bookkeeping
	int pwmCycle;
	int blHigh;
	int blWindows;
	int testErrors;
	// Horizontal sync bookkeeping
	int hPhase;
	int hsWidth;
	logic lineStarted;
	logic hsLast;
	logic deLast;
	logic vsLast;
	logic [LaneCount*ColorBits-1:0] expPixel;
	logic [LaneCount*ColorBits-1:0] gotPixel;

	initial
	begin
		errorCount  = 0;
		testsRun    = 0;
		testsFailed = 0;
	end

	// One component from the pattern rule
	function automatic logic [ColorBits-1:0] expectComp(patternMode_t mode, int x, int y,
		logic [ColorBits-1:0] lvl);
		logic [ColorBits-1:0] xLow;
		logic [ColorBits-1:0] yLow;
		xLow = x[ColorBits-1:0];
		yLow = y[ColorBits-1:0];
		case (mode)
			patSolid:   return lvl;
			patHRamp:   return xLow + lvl;
			patVRamp:   return yLow + lvl;
			// Level only where bits 3 differ
			patChecker: return (x[3] != y[3]) ? lvl : '0;
			default:    return '0;
		endcase
	endfunction

	task automatic flagError(string what, int expected, int actual);
		// Only the first few per test reach the log
		if (testErrors < 10)
			$display("ERR %0s %0s expected %0h actual %0h", testName, what, expected, actual);
		testErrors++;
		errorCount++;
	endtask

	// --------------------
	// Pin watcher
	// --------------------

	always @(posedge iVideoClk)
	begin
		gotPixel = {tftColorR, tftColorG, tftColorB};
		if (reset)
		begin
			xPos        = 0;
			lineIdx     = 0;
			framesSeen  = 0;
			pwmCycle    = 0;
			blHigh      = 0;
			blWindows   = 0;
			testErrors  = 0;
			hPhase      = 0;
			hsWidth     = 0;
			lineStarted = 1'b0;
			hsLast      = 1'b0;
			deLast      = 1'b0;
			vsLast      = 1'b0;
		end
		else
		begin
			if (tftDe)
			begin
				// New line starts on the rising edge of enable
				if (!deLast)
				begin
					xPos        = 0;
					hPhase      = 0;
					lineStarted = 1'b1;
				end
				for (int lane = 0; lane < LaneCount; lane++)
					expPixel[(LaneCount-1-lane)*ColorBits +: ColorBits] = expectComp(patternMode,
						xPos, lineIdx, laneLevel[(LaneCount-1-lane)*ColorBits +: ColorBits]);
				if (gotPixel != expPixel)
					flagError($sformatf("pixel x=%0d y=%0d", xPos, lineIdx), expPixel, gotPixel);
				xPos++;
			end
			else
			begin
				if (gotPixel != '0)
					flagError("blanked colour", 0, gotPixel);
				// Line just ended
				if (deLast)
				begin
					if (xPos != hDisplay)
						flagError("enable cycles per line", hDisplay, xPos);
					lineIdx++;
				end
			end
			// Vertical sync sits in blanking, so the frame is complete here
			if (tftVSync && !vsLast)
			begin
				if (lineIdx != vDisplay)
					flagError("lines per frame", vDisplay, lineIdx);
				lineIdx = 0;
				framesSeen++;
			end
			// Sync rises hSyncStart clocks after the first enable of the line
			if (tftHSync && !hsLast && lineStarted)
			begin
				if (hPhase != hSyncStart)
					flagError("hsync start", hSyncStart, hPhase);
				lineStarted = 1'b0;
			end
			// Pulse width from the window bounds
			if (!tftHSync && hsLast && hsWidth != hSyncEnd - hSyncStart)
				flagError("hsync width", hSyncEnd - hSyncStart, hsWidth);
			hsWidth = tftHSync ? hsWidth + 1 : 0;
			hPhase++;
			hsLast = tftHSync;
			deLast = tftDe;
			vsLast = tftVSync;
			// Windows of one PWM period, after the first full period
			if (pwmCycle >= (1 << PwmBits))
			begin
				if (tftBackLight)
					blHigh++;
				if (pwmCycle % (1 << PwmBits) == (1 << PwmBits) - 1)
				begin
					if (blHigh != blDuty)
						flagError("backlight high cycles", blDuty, blHigh);
					blHigh = 0;
					blWindows++;
				end
			end
			pwmCycle++;
		end
		// --------------------
		// Per-test result
		// --------------------
		if (testEnd)
		begin
			if (framesSeen == 0)
			begin
				$display("%0s: no complete frame was seen on the pins", testName);
				testErrors++;
				errorCount++;
			end
			if (blWindows == 0)
			begin
				$display("%0s: backlight duty was never measured", testName);
				testErrors++;
				errorCount++;
			end
			testsRun++;
			if (testErrors != 0)
				testsFailed++;
			$display("Test %0s: %0s, %0d frames, %0d errors", testName,
				(testErrors != 0) ? "failed" : "ok", framesSeen, testErrors);
		end
	end

endmodule

/* tests/VideoTxTb.sv */
// Video transmitter testbench top with clock, reset, stimulus table, frame waits and summary
`timescale 1ns/10ps

module VideoTxTb;

	import VideoTxPkg::*;

	// One table entry
	typedef struct packed {
		logic [8*12-1:0]        name;
		logic [HdisplayWidth-1:0] hDisp;
		logic [VdisplayWidth-1:0] vDisp;
		logic [HdisplayWidth:0] hMax;
		logic [VdisplayWidth:0] vMax;
		patternMode_t           mode;
		logic [LaneCount*ColorBits-1:0] level;
		logic                   randLevel;
		logic [PwmBits-1:0]     duty;
	} stimRow_t;

	logic iVideoClk;
	logic reset;
	logic [HdisplayWidth-1:0] hDisplay;
	logic [VdisplayWidth-1:0] vDisplay;
	logic [HdisplayWidth:0]   hSyncStart;
	logic [HdisplayWidth:0]   hSyncEnd;
	logic [HdisplayWidth:0]   hSyncMax;
	logic [VdisplayWidth:0]   vSyncStart;
	logic [VdisplayWidth:0]   vSyncEnd;
	logic [VdisplayWidth:0]   vSyncMax;
	patternMode_t             patternMode;
	logic [LaneCount*ColorBits-1:0] laneLevel;
	logic [PwmBits-1:0]       blDuty;
	logic [ColorBits-1:0]     tftColorR;
	logic [ColorBits-1:0]     tftColorG;
	logic [ColorBits-1:0]     tftColorB;
	logic tftHSync;
	logic tftVSync;
	logic tftDe;
	logic tftBackLight;
	logic frameEnd;
	// Checker side
	logic testEnd;
	logic [8*12-1:0] testName;
	int errorCount;
	int testsRun;
	int testsFailed;
	stimRow_t stimTable [6];

	VideoTxUnit dut_i
	(
		.iVideoClk (iVideoClk), .reset (reset),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .hSyncMax (hSyncMax),
		.vSyncStart (vSyncStart), .vSyncEnd (vSyncEnd), .vSyncMax (vSyncMax),
		.patternMode (patternMode), .laneLevel (laneLevel), .blDuty (blDuty),
		.tftColorR (tftColorR), .tftColorG (tftColorG), .tftColorB (tftColorB),
		.tftHSync (tftHSync), .tftVSync (tftVSync), .tftDe (tftDe),
		.tftBackLight (tftBackLight), .frameEnd (frameEnd)
	);

	VideoTxChecker chk_i
	(
		.iVideoClk (iVideoClk), .reset (reset), .testEnd (testEnd), .testName (testName),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .patternMode (patternMode),
		.laneLevel (laneLevel), .blDuty (blDuty),
		.tftColorR (tftColorR), .tftColorG (tftColorG), .tftColorB (tftColorB),
		.tftHSync (tftHSync), .tftVSync (tftVSync), .tftDe (tftDe),
		.tftBackLight (tftBackLight),
		.errorCount (errorCount), .testsRun (testsRun), .testsFailed (testsFailed)
	);

	// 4 ns period
	initial iVideoClk = 1'b0;
	always #2 iVideoClk = ~iVideoClk;

	// --------------------
	// Helpers
	// --------------------

	// Inputs change 1 ns after the rising edge
	task automatic stepCycle();
		@(posedge iVideoClk);
		#1;
	endtask

	// Timing and pattern only change under reset
	task automatic applyRow(input stimRow_t row);
		reset       = 1'b1;
		testName    = row.name;
		hDisplay    = row.hDisp;
		vDisplay    = row.vDisp;
		hSyncMax    = row.hMax;
		vSyncMax    = row.vMax;
		// Sync windows inside the blanking
		hSyncStart  = row.hDisp + 2;
		hSyncEnd    = row.hDisp + 5;
		vSyncStart  = row.vDisp;
		vSyncEnd    = row.vDisp + 1;
		patternMode = row.mode;
		laneLevel   = row.randLevel ? ($urandom() % 4096) : row.level;
		blDuty      = row.duty;
		repeat (8) stepCycle();
		reset = 1'b0;
	endtask

	// Largest frame in the table is well under 2000 clocks
	task automatic waitFrameEnd(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < 2000 && !seen; n++)
		begin
			stepCycle();
			if (frameEnd)
				seen = 1'b1;
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		bit seen;
		void'($urandom(32'h6036));
		reset = 1'b1;
		testEnd = 1'b0;
		testName = "none";
		{hDisplay, vDisplay, hSyncStart, hSyncEnd, hSyncMax} = '0;
		{vSyncStart, vSyncEnd, vSyncMax, laneLevel, blDuty} = '0;
		patternMode = patSolid;
		// Name, active h and v, last h and v count, opcode, levels, random, duty
		stimTable[0] = '{"solid", 11'd20, 11'd12, 12'd27, 12'd13, patSolid, 12'h5A3, 1'b0, 8'd100};
		stimTable[1] = '{"solidRand", 11'd20, 11'd12, 12'd27, 12'd13, patSolid, 12'h0, 1'b1, 8'd0};
		stimTable[2] = '{"hRamp", 11'd24, 11'd10, 12'd31, 12'd12, patHRamp, 12'h3C7, 1'b0, 8'd255};
		stimTable[3] = '{"vRamp", 11'd20, 11'd16, 12'd25, 12'd18, patVRamp, 12'h0, 1'b1, 8'd37};
		stimTable[4] = '{"checker", 11'd20, 11'd12, 12'd27, 12'd13, patChecker, 12'hF9A, 1'b0, 8'd128};
		stimTable[5] = '{"checkerRand", 11'd18, 11'd12, 12'd27, 12'd13, patChecker, 12'h0, 1'b1, 8'd1};
		foreach (stimTable[i])
		begin
			applyRow(stimTable[i]);
			// Two full frames per entry
			for (int f = 0; f < 2; f++)
			begin
				waitFrameEnd(seen);
				if (!seen)
				begin
					$display("Timeout waiting for frameEnd in test %0s", testName);
					$display("Simulation finished: FAIL");
					$finish;
				end
			end
			testEnd = 1'b1;
			stepCycle();
			testEnd = 1'b0;
		end
		$display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, errorCount, dut_i.sva_i.assertFails);
		if (testsFailed == 0 && errorCount == 0 && dut_i.sva_i.assertFails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* VideoTx.f */
src/VideoTxPkg.sv
src/VideoSyncGen.sv
src/ColorLane.sv
src/TftOutput.sv
src/BacklightPwm.sv
src/VideoTxUnit.sv
tests/VideoTx_sva.sv
tests/VideoTxChecker.sv
tests/VideoTxTb.sv
